// ==== Makefile ====
# Verilator lint, build and run for the rv64i execute stage

TOP       ?= tb_ex_stage
FLIST     ?= ex_stage.f
SEED      ?= 1
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
VERILATOR ?= verilator
VFLAGS    ?= --timing --timescale 1ns/100ps
FAIL_MSG  := Test failures found

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# a crashed run counts as a failure too
sim: build
	./$(OBJ_DIR)/V$(TOP) +verilator+seed+$(SEED) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== ex_alu.sv ====
// integer alu of the execute stage
// 64-bit ops plus rv64 word ops with sign-extended 32-bit results
`timescale 1ns/100ps
`default_nettype none

module ex_alu
    import ex_pkg::*;
(
    input  dec_t  dec_i,
    output xlen_t alu_res_o
);

    logic [5:0] shamt;
    word_t      opa_w;
    word_t      opb_w;
    word_t      res_w;
    xlen_t      res_d;

    // word ops only see the low 5 shift bits
    assign shamt = dec_i.word_op ? {1'b0, dec_i.opb[4:0]} : dec_i.opb[5:0];
    assign opa_w = dec_i.opa[31:0];
    assign opb_w = dec_i.opb[31:0];

    always_comb begin
        case (dec_i.alu_op)
            ALU_ADD:  res_d = dec_i.opa + dec_i.opb;
            ALU_SUB:  res_d = dec_i.opa - dec_i.opb;
            ALU_SLL:  res_d = dec_i.opa << shamt;
            ALU_SLT:  res_d = {63'b0, ($signed(dec_i.opa) < $signed(dec_i.opb))};
            ALU_SLTU: res_d = {63'b0, (dec_i.opa < dec_i.opb)};
            ALU_XOR:  res_d = dec_i.opa ^ dec_i.opb;
            ALU_SRL:  res_d = dec_i.opa >> shamt;
            ALU_SRA:  res_d = $signed(dec_i.opa) >>> shamt;   // fills with bit 63
            ALU_OR:   res_d = dec_i.opa | dec_i.opb;
            ALU_AND:  res_d = dec_i.opa & dec_i.opb;
            default:  res_d = '0;
        endcase
    end

    // addw, subw and the word shifts
    always_comb begin
        case (dec_i.alu_op)
            ALU_ADD: res_w = opa_w + opb_w;
            ALU_SUB: res_w = opa_w - opb_w;
            ALU_SLL: res_w = opa_w << shamt[4:0];
            ALU_SRL: res_w = opa_w >> shamt[4:0];
            ALU_SRA: res_w = $signed(opa_w) >>> shamt[4:0];   // fills with bit 31
            default: res_w = res_d[31:0];
        endcase
    end

    assign alu_res_o = dec_i.word_op ? {{32{res_w[31]}}, res_w} : res_d;

endmodule

`default_nettype wire

// ==== ex_branch.sv ====
// branch unit: condition compare and target adder
`timescale 1ns/100ps
`default_nettype none

module ex_branch
    import ex_pkg::*;
(
    input  dec_t  dec_i,
    output jump_t jump_o
);

    logic eq;
    logic lt_s;
    logic lt_u;
    logic cond;

    assign eq   = (dec_i.opa == dec_i.opb);
    assign lt_s = ($signed(dec_i.opa) < $signed(dec_i.opb));
    assign lt_u = (dec_i.opa < dec_i.opb);

    always_comb begin
        case (dec_i.branch_funct)
            F3_BEQ:  cond = eq;
            F3_BNE:  cond = !eq;
            F3_BLT:  cond = lt_s;
            F3_BGE:  cond = !lt_s;
            F3_BLTU: cond = lt_u;
            F3_BGEU: cond = !lt_u;
            default: cond = 1'b0;
        endcase
    end

    assign jump_o.taken  = dec_i.valid && (dec_i.op_class == CLS_BRANCH) && cond;
    assign jump_o.target = jump_o.taken ? (dec_i.pc + dec_i.branch_imm) : '0;   // zero if not taken

endmodule

`default_nettype wire

// ==== ex_decode.sv ====
// execute stage input side
// splits the instruction, builds immediates, picks class, alu op and operands
`timescale 1ns/100ps
`default_nettype none

module ex_decode
    import ex_pkg::*;
(
    input  ex_in_t ex_in_i,
    output dec_t   dec_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       f7_base;
    logic       f7_alt;
    logic       f6_base;
    logic       f6_alt;
    xlen_t      imm_i;
    xlen_t      imm_s;
    xlen_t      imm_b;
    xlen_t      imm_sel;
    logic       use_imm;
    logic       word_op;
    op_class_e  op_class;
    alu_op_e    alu_op;

    function automatic alu_op_e f3_to_op(input logic [2:0] f3, input logic alt_sel);
        alu_op_e op;
        case (f3)
            F3_ADD_SUB: op = alt_sel ? ALU_SUB : ALU_ADD;
            F3_SLL:     op = ALU_SLL;
            F3_SLT:     op = ALU_SLT;
            F3_SLTU:    op = ALU_SLTU;
            F3_XOR:     op = ALU_XOR;
            F3_SR:      op = alt_sel ? ALU_SRA : ALU_SRL;
            F3_OR:      op = ALU_OR;
            default:    op = ALU_AND;
        endcase
        return op;
    endfunction

    assign opcode  = ex_in_i.inst[6:0];
    assign funct3  = ex_in_i.inst[14:12];
    assign funct7  = ex_in_i.inst[31:25];
    assign f7_base = (funct7 == F7_BASE);
    assign f7_alt  = (funct7 == F7_ALT);
    assign f6_base = (funct7[6:1] == F7_BASE[6:1]);  // slli/srai use inst[25] as shamt[5]
    assign f6_alt  = (funct7[6:1] == F7_ALT[6:1]);

    assign imm_i = {{52{ex_in_i.inst[31]}}, ex_in_i.inst[31:20]};
    assign imm_s = {{52{ex_in_i.inst[31]}}, ex_in_i.inst[31:25], ex_in_i.inst[11:7]};
    assign imm_b = {{51{ex_in_i.inst[31]}}, ex_in_i.inst[31], ex_in_i.inst[7],
                    ex_in_i.inst[30:25], ex_in_i.inst[11:8], 1'b0};

    always_comb begin
        op_class = CLS_NONE;
        alu_op   = ALU_ADD;     // loads, stores and branches stay on add
        word_op  = 1'b0;
        use_imm  = 1'b0;
        imm_sel  = imm_i;
        case (opcode)
            OPC_OP: begin
                if (f7_base || (f7_alt && (funct3 == F3_ADD_SUB || funct3 == F3_SR))) begin
                    op_class = CLS_ALU;
                    alu_op   = f3_to_op(funct3, f7_alt);
                end
            end
            OPC_OP_IMM: begin
                use_imm = 1'b1;
                if ((funct3 != F3_SLL && funct3 != F3_SR) || f6_base ||
                    (funct3 == F3_SR && f6_alt)) begin
                    op_class = CLS_ALU;
                    alu_op   = f3_to_op(funct3, funct3 == F3_SR && f6_alt);
                end
            end
            OPC_OP_32: begin
                if ((funct3 == F3_ADD_SUB || funct3 == F3_SLL || funct3 == F3_SR) &&
                    (f7_base || (f7_alt && funct3 != F3_SLL))) begin
                    op_class = CLS_ALU;
                    alu_op   = f3_to_op(funct3, f7_alt);
                    word_op  = 1'b1;
                end
            end
            OPC_OP_IMM_32: begin
                use_imm = 1'b1;
                if (funct3 == F3_ADD_SUB || (funct3 == F3_SLL && f7_base) ||
                    (funct3 == F3_SR && (f7_base || f7_alt))) begin
                    op_class = CLS_ALU;
                    alu_op   = f3_to_op(funct3, funct3 == F3_SR && f7_alt);
                    word_op  = 1'b1;
                end
            end
            OPC_LOAD: begin
                use_imm = 1'b1;
                if (funct3 inside {F3_LB, F3_LH, F3_LW, F3_LD, F3_LBU, F3_LHU, F3_LWU}) begin
                    op_class = CLS_LOAD;
                end
            end
            OPC_STORE: begin
                use_imm = 1'b1;
                imm_sel = imm_s;
                if (funct3 inside {F3_SB, F3_SH, F3_SW, F3_SD}) begin
                    op_class = CLS_STORE;
                end
            end
            OPC_BRANCH: begin
                // opb stays rs2 for the compare
                if (funct3 inside {F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU}) begin
                    op_class = CLS_BRANCH;
                end
            end
            default: op_class = CLS_NONE;
        endcase
        if (!ex_in_i.valid) begin
            op_class = CLS_NONE;
        end
    end

    assign dec_o.valid        = ex_in_i.valid;
    assign dec_o.op_class     = op_class;
    assign dec_o.alu_op       = alu_op;
    assign dec_o.word_op      = word_op;
    assign dec_o.opa          = ex_in_i.rs1_val;
    assign dec_o.opb          = use_imm ? imm_sel : ex_in_i.rs2_val;
    assign dec_o.pc           = ex_in_i.pc;
    assign dec_o.branch_imm   = imm_b;
    assign dec_o.branch_funct = funct3;
    assign dec_o.store_val    = ex_in_i.rs2_val;
    assign dec_o.mem_size     = mem_size_e'(funct3[1:0]);
    assign dec_o.rd           = ex_in_i.rd;
    // only alu ops and loads ever write a register
    assign dec_o.rd_we        = ex_in_i.rd_we &&
                                (op_class == CLS_ALU || op_class == CLS_LOAD);

endmodule

`default_nettype wire

// ==== ex_pkg.sv ====
// shared types for the rv64i integer execute stage
// opcode and funct encodings, decode enums and stage structs
`default_nettype none

package ex_pkg;

    typedef logic [63:0] xlen_t;      // full register word
    typedef logic [31:0] word_t;      // low half for *w ops
    typedef logic [31:0] inst_t;
    typedef logic [4:0]  reg_addr_t;

    // major opcodes
    localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
    localparam logic [6:0] OPC_OP        = 7'b0110011;
    localparam logic [6:0] OPC_LOAD      = 7'b0000011;
    localparam logic [6:0] OPC_STORE     = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH    = 7'b1100011;
    localparam logic [6:0] OPC_OP_IMM_32 = 7'b0011011;
    localparam logic [6:0] OPC_OP_32     = 7'b0111011;

    // alu funct3, shared by reg, imm and word forms
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SR      = 3'b101;   // srl / sra
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // loads
    localparam logic [2:0] F3_LB  = 3'b000;
    localparam logic [2:0] F3_LH  = 3'b001;
    localparam logic [2:0] F3_LW  = 3'b010;
    localparam logic [2:0] F3_LD  = 3'b011;
    localparam logic [2:0] F3_LBU = 3'b100;
    localparam logic [2:0] F3_LHU = 3'b101;
    localparam logic [2:0] F3_LWU = 3'b110;

    // stores
    localparam logic [2:0] F3_SB = 3'b000;
    localparam logic [2:0] F3_SH = 3'b001;
    localparam logic [2:0] F3_SW = 3'b010;
    localparam logic [2:0] F3_SD = 3'b011;

    // branches
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;   // bit 30 set, sub / sra

    typedef enum logic [2:0] {
        CLS_NONE,
        CLS_ALU,
        CLS_LOAD,
        CLS_STORE,
        CLS_BRANCH
    } op_class_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

    // matches funct3[1:0] of the stores
    typedef enum logic [1:0] {
        MEM_BYTE,
        MEM_HALF,
        MEM_WORD,
        MEM_DOUBLE
    } mem_size_e;

    typedef struct packed {
        logic      valid;
        inst_t     inst;
        xlen_t     pc;
        xlen_t     rs1_val;
        xlen_t     rs2_val;
        reg_addr_t rd;
        logic      rd_we;
    } ex_in_t;

    typedef struct packed {
        logic      valid;
        op_class_e op_class;
        alu_op_e   alu_op;
        logic      word_op;
        xlen_t     opa;
        xlen_t     opb;
        xlen_t     pc;
        xlen_t     branch_imm;
        logic [2:0] branch_funct;
        xlen_t     store_val;
        mem_size_e mem_size;
        reg_addr_t rd;
        logic      rd_we;
    } dec_t;

    typedef struct packed {
        logic      we;
        reg_addr_t rd;
        xlen_t     data;
    } wb_t;

    typedef struct packed {
        logic  ce;
        logic  we;
        xlen_t addr;    // one address for read and write
        xlen_t wdata;
    } mem_req_t;

    typedef struct packed {
        logic  taken;
        xlen_t target;
    } jump_t;

endpackage

`default_nettype wire

// ==== ex_stage.f ====
+incdir+.
ex_pkg.sv
ex_decode.sv
ex_alu.sv
ex_branch.sv
ex_writeback.sv
ex_stage.sv
tb_ex_stage.sv

// ==== ex_stage.sv ====
// rv64i integer execute stage top
// decode, alu and branch unit feed one registered output side
`timescale 1ns/100ps
`default_nettype none

module ex_stage
    import ex_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_n_i,
    input  ex_in_t   ex_in_i,
    output wb_t      wb_o,
    output mem_req_t mem_o,
    output jump_t    jump_o
);

    dec_t  dec;
    xlen_t alu_res;
    jump_t jump;

    ex_decode u_decode (
        .ex_in_i (ex_in_i),
        .dec_o   (dec)
    );

    ex_alu u_alu (
        .dec_i     (dec),
        .alu_res_o (alu_res)
    );

    ex_branch u_branch (
        .dec_i  (dec),
        .jump_o (jump)
    );

    // the only register stage
    ex_writeback u_writeback (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .dec_i     (dec),
        .alu_res_i (alu_res),
        .jump_i    (jump),
        .wb_o      (wb_o),
        .mem_o     (mem_o),
        .jump_o    (jump_o)
    );

endmodule

`default_nettype wire

// ==== ex_writeback.sv ====
// execute stage output side
// forms writeback, memory request and jump, registers them for one cycle
`timescale 1ns/100ps
`default_nettype none

module ex_writeback
    import ex_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_n_i,
    input  dec_t     dec_i,
    input  xlen_t    alu_res_i,
    input  jump_t    jump_i,
    output wb_t      wb_o,
    output mem_req_t mem_o,
    output jump_t    jump_o
);

    wb_t      wb_d;
    mem_req_t mem_d;

    always_comb begin
        wb_d  = '0;
        mem_d = '0;
        if (dec_i.valid) begin
            wb_d.we = dec_i.rd_we;
            wb_d.rd = dec_i.rd_we ? dec_i.rd : '0;
            // load data comes back in a later stage
            if (dec_i.op_class == CLS_ALU) begin
                wb_d.data = alu_res_i;
            end
            if (dec_i.op_class == CLS_LOAD || dec_i.op_class == CLS_STORE) begin
                mem_d.ce   = 1'b1;
                mem_d.addr = alu_res_i;   // rs1 + imm
            end
            if (dec_i.op_class == CLS_STORE) begin
                mem_d.we = 1'b1;
                case (dec_i.mem_size)
                    MEM_BYTE: mem_d.wdata = {56'b0, dec_i.store_val[7:0]};
                    MEM_HALF: mem_d.wdata = {48'b0, dec_i.store_val[15:0]};
                    MEM_WORD: mem_d.wdata = {32'b0, dec_i.store_val[31:0]};
                    default:  mem_d.wdata = dec_i.store_val;
                endcase
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wb_o   <= '0;
            mem_o  <= '0;
            jump_o <= '0;
        end else begin
            wb_o   <= wb_d;
            mem_o  <= mem_d;
            jump_o <= jump_i;   // already zero unless taken
        end
    end

endmodule

`default_nettype wire

// ==== tb_ex_checks.svh ====
// typed compare tasks and check counters for the execute stage testbench
`ifndef TB_EX_CHECKS_SVH
`define TB_EX_CHECKS_SVH

int unsigned pass_cnt = 0;
int unsigned fail_cnt = 0;

task automatic check_word(input string name, input xlen_t exp, input xlen_t act);
    if (act !== exp) begin
        $display("FAILED %s: expected %h, actual %h", name, exp, act);
        fail_cnt++;
    end else begin
        pass_cnt++;
    end
endtask

task automatic check_reg_addr(input string name, input reg_addr_t exp, input reg_addr_t act);
    if (act !== exp) begin
        $display("FAILED %s: expected x%0d, actual x%0d", name, exp, act);
        fail_cnt++;
    end else begin
        pass_cnt++;
    end
endtask

task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
        $display("FAILED %s: expected %b, actual %b", name, exp, act);
        fail_cnt++;
    end else begin
        pass_cnt++;
    end
endtask

// one summary line per test
task automatic end_test(input string name, input int unsigned fails_at_start);
    if (fail_cnt == fails_at_start) begin
        $display("test %s: ok", name);
    end else begin
        $display("test %s: %0d mismatches", name, fail_cnt - fails_at_start);
    end
endtask

`endif

// ==== tb_ex_stage.sv ====
// directed testbench for the rv64i execute stage
// drives instructions with operands, checks writeback, memory and jump outputs
`timescale 1ns/100ps
`default_nettype none

module tb_ex_stage
    import ex_pkg::*;
();

    localparam int max_cycles = 2000;   // tests take about 340 cycles

    logic     clk;
    logic     rst_n;
    ex_in_t   ex_in;
    wb_t      wb;
    mem_req_t mem;
    jump_t    jmp;
    integer   seed = 17823;
    int       cycle_cnt = 0;

    `include "tb_ex_checks.svh"

    ex_stage dut0 (
        .clk_i   (clk),
        .rst_n_i (rst_n),
        .ex_in_i (ex_in),
        .wb_o    (wb),
        .mem_o   (mem),
        .jump_o  (jmp)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= max_cycles) begin
            $display("timeout: tests did not finish within %0d cycles", max_cycles);
            $display("Test failures found");
            $finish;
        end
    end

    function automatic xlen_t rand64();
        return {$random(seed), $random(seed)};
    endfunction

    function automatic xlen_t sext12(input logic [11:0] imm);
        return {{52{imm[11]}}, imm};
    endfunction

    // register fields are don't care since operands travel separately
    function automatic inst_t r_type(input logic [6:0] f7, input logic [2:0] fn,
                                     input logic [6:0] opc);
        return {f7, 5'd7, 5'd6, fn, 5'd5, opc};
    endfunction

    function automatic inst_t i_type(input logic [11:0] imm, input logic [2:0] fn,
                                     input logic [6:0] opc);
        return {imm, 5'd6, fn, 5'd5, opc};
    endfunction

    function automatic inst_t s_type(input logic [11:0] imm, input logic [2:0] fn);
        return {imm[11:5], 5'd7, 5'd6, fn, imm[4:0], OPC_STORE};
    endfunction

    function automatic inst_t b_type(input logic [12:0] imm, input logic [2:0] fn);
        return {imm[12], imm[10:5], 5'd7, 5'd6, fn, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic ex_in_t make_item(input inst_t inst, input xlen_t pc, input xlen_t rs1,
                                         input xlen_t rs2, input reg_addr_t rd);
        ex_in_t it;
        it.valid   = 1'b1;
        it.inst    = inst;
        it.pc      = pc;
        it.rs1_val = rs1;
        it.rs2_val = rs2;
        it.rd      = rd;
        it.rd_we   = 1'b1;
        return it;
    endfunction

    // reference model with right shifts built from a logical shift and a fill mask
    function automatic xlen_t ref_alu(input logic [2:0] fn, input logic alt, input logic word,
                                      input xlen_t a, input xlen_t b);
        xlen_t      r;
        word_t      w;
        logic [5:0] sh;
        sh = word ? {1'b0, b[4:0]} : b[5:0];
        if (word) begin
            case (fn)
                F3_ADD_SUB: w = alt ? a[31:0] - b[31:0] : a[31:0] + b[31:0];
                F3_SLL:     w = a[31:0] << sh;
                default:    w = (a[31:0] >> sh) |
                                ((alt && a[31]) ? ~(32'hffff_ffff >> sh) : 32'h0);
            endcase
            r = {{32{w[31]}}, w};
        end else begin
            case (fn)
                F3_ADD_SUB: r = alt ? a - b : a + b;
                F3_SLL:     r = a << sh;
                F3_SLT:     r = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
                F3_SLTU:    r = (a < b) ? 64'd1 : 64'd0;
                F3_XOR:     r = a ^ b;
                F3_SR:      r = (a >> sh) | ((alt && a[63]) ? ~({64{1'b1}} >> sh) : 64'h0);
                F3_OR:      r = a | b;
                default:    r = a & b;
            endcase
        end
        return r;
    endfunction

    function automatic logic branch_rule(input logic [2:0] fn, input xlen_t a, input xlen_t b);
        case (fn)
            F3_BEQ:  return a == b;
            F3_BNE:  return a != b;
            F3_BLT:  return $signed(a) < $signed(b);
            F3_BGE:  return $signed(a) >= $signed(b);
            F3_BLTU: return a < b;
            default: return a >= b;
        endcase
    endfunction

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic check_idle(input string name);
        check_flag(name, 1'b0, wb.we);
        check_flag(name, 1'b0, mem.ce);
        check_flag(name, 1'b0, mem.we);
        check_flag(name, 1'b0, jmp.taken);
        check_reg_addr(name, 5'd0, wb.rd);
        check_word(name, 64'h0, wb.data);
        check_word(name, 64'h0, mem.addr);
        check_word(name, 64'h0, mem.wdata);
        check_word(name, 64'h0, jmp.target);
    endtask

    // one alu item with its result one cycle later
    task automatic run_alu(input string name, input inst_t inst, input xlen_t a, input xlen_t rs2);
        reg_addr_t rd;
        xlen_t     opb;
        logic      alt;
        logic      we;
        rd  = reg_addr_t'($random(seed));
        we  = 1'($random(seed));
        opb = inst[5] ? rs2 : sext12(inst[31:20]);   // OP and OP-32 take rs2
        alt = inst[30] && (inst[14:12] == F3_SR || (inst[14:12] == F3_ADD_SUB && inst[5]));
        ex_in = make_item(inst, rand64(), a, rs2, rd);
        ex_in.rd_we = we;
        step();
        check_word(name, ref_alu(inst[14:12], alt, inst[3], a, opb), wb.data);
        if (we) begin
            check_reg_addr(name, rd, wb.rd);
        end
        check_flag(name, we, wb.we);
    endtask

    task automatic reset_idle();
        int unsigned fails0;
        ex_in_t      busy[3];
        fails0 = fail_cnt;
        // live alu, store and branch items that reset has to mask
        busy[0] = make_item(r_type(F7_BASE, F3_ADD_SUB, OPC_OP), 64'h0, 64'h11, 64'h22, 5'd9);
        busy[1] = make_item(s_type(12'h010, F3_SD), 64'h0, 64'h40, 64'h55, 5'd3);
        busy[2] = make_item(b_type(13'h020, F3_BEQ), 64'h200, 64'h7, 64'h7, 5'd4);
        for (int i = 0; i < 10; i++) begin
            step();
            if (i >= 7) begin
                check_idle("in reset");
            end
            ex_in = busy[i % 3];
        end
        rst_n = 1'b1;
        ex_in = make_item(r_type(F7_BASE, F3_ADD_SUB, OPC_OP), 64'h0, rand64(), rand64(), 5'd9);
        ex_in.valid = 1'b0;   // rd_we still set
        step();
        check_idle("valid low");
        end_test("reset and idle", fails0);
    endtask

    task automatic alu_ops();
        int unsigned fails0;
        logic [2:0]  fn;
        logic [11:0] imm;
        logic        alt;
        fails0 = fail_cnt;
        for (int f = 0; f < 8; f++) begin
            fn = 3'(f);
            for (int k = 0; k < 16; k++) begin
                alt = ((k % 2) == 1) && (fn == F3_ADD_SUB || fn == F3_SR);
                run_alu($sformatf("op f3=%0d alt=%0d", fn, alt),
                        r_type(alt ? F7_ALT : F7_BASE, fn, OPC_OP), rand64(), rand64());
                imm = 12'($random(seed));
                if (fn == F3_SLL || fn == F3_SR) begin
                    imm[11:6] = {1'b0, (alt && (fn == F3_SR)), 4'b0};
                end
                run_alu($sformatf("op-imm f3=%0d", fn), i_type(imm, fn, OPC_OP_IMM),
                        rand64(), rand64());
            end
        end
        // shifts at the 63 boundary
        run_alu("sra by 63", r_type(F7_ALT, F3_SR, OPC_OP), 64'h8000_0000_0000_1234, 64'hff);
        run_alu("srai by 63", i_type({6'b010000, 6'd63}, F3_SR, OPC_OP_IMM),
                64'hc000_0000_0000_0000, rand64());
        run_alu("srl by 63", r_type(F7_BASE, F3_SR, OPC_OP), 64'h8000_0000_0000_0000, 64'h3f);
        run_alu("sll by 63", r_type(F7_BASE, F3_SLL, OPC_OP), 64'h3, 64'h3f);
        ex_in = '0;
        end_test("alu operations", fails0);
    endtask

    // low words picked so that bit 31 of each result is set
    task automatic word_ops();
        int unsigned fails0;
        xlen_t hi;
        xlen_t lo;
        fails0 = fail_cnt;
        hi = rand64();
        lo = rand64();
        run_alu("addw", r_type(F7_BASE, F3_ADD_SUB, OPC_OP_32),
                {hi[63:32], 32'h7fff_fff0}, {lo[63:32], 32'h20});
        run_alu("subw", r_type(F7_ALT, F3_ADD_SUB, OPC_OP_32),
                {hi[63:32], 32'h10}, {lo[63:32], 32'h20});
        run_alu("sllw", r_type(F7_BASE, F3_SLL, OPC_OP_32),
                {hi[63:32], 32'h1}, {lo[63:6], 6'h3f});
        run_alu("srlw", r_type(F7_BASE, F3_SR, OPC_OP_32),
                {hi[63:32], 32'h8000_1234}, {lo[63:6], 6'h20});   // bit 5 ignored
        run_alu("sraw", r_type(F7_ALT, F3_SR, OPC_OP_32),
                {hi[63:32], 32'h9000_0000}, {lo[63:5], 5'd7});
        run_alu("addiw", i_type(12'd1, F3_ADD_SUB, OPC_OP_IMM_32),
                {hi[63:32], 32'h7fff_ffff}, lo);
        run_alu("slliw", i_type(12'd31, F3_SLL, OPC_OP_IMM_32), {hi[63:32], 32'h1}, lo);
        run_alu("srliw", i_type(12'd0, F3_SR, OPC_OP_IMM_32), {hi[63:32], 32'hf000_0000}, lo);
        run_alu("sraiw", i_type({7'b0100000, 5'd12}, F3_SR, OPC_OP_IMM_32),
                {hi[63:32], 32'h8765_4321}, lo);
        ex_in = '0;
        end_test("word operations", fails0);
    endtask

    task automatic mem_ops();
        int unsigned fails0;
        xlen_t       a;
        xlen_t       b;
        xlen_t       mask;
        logic [11:0] imm;
        reg_addr_t   rd;
        fails0 = fail_cnt;
        for (int k = 0; k < 7; k++) begin
            a   = rand64();
            imm = 12'($random(seed));
            rd  = reg_addr_t'($random(seed));
            ex_in = make_item(i_type(imm, 3'(k), OPC_LOAD), rand64(), a, rand64(), rd);
            step();
            check_flag("load ce", 1'b1, mem.ce);
            check_flag("load we", 1'b0, mem.we);
            check_word("load addr", a + sext12(imm), mem.addr);
            check_flag("load rd_we", 1'b1, wb.we);
            check_reg_addr("load rd", rd, wb.rd);
        end
        for (int k = 0; k < 4; k++) begin
            a   = rand64();
            b   = rand64();
            imm = 12'($random(seed));
            case (k)
                0:       mask = 64'hff;
                1:       mask = 64'hffff;
                2:       mask = 64'hffff_ffff;
                default: mask = {64{1'b1}};
            endcase
            ex_in = make_item(s_type(imm, 3'(k)), rand64(), a, b, 5'd7);
            step();
            check_flag("store ce", 1'b1, mem.ce);
            check_flag("store we", 1'b1, mem.we);
            check_word("store addr", a + sext12(imm), mem.addr);
            check_word("store data", b & mask, mem.wdata);
            check_flag("store rd_we", 1'b0, wb.we);
        end
        ex_in = '0;
        end_test("loads and stores", fails0);
    endtask

    task automatic branch_ops();
        int unsigned fails0;
        xlen_t       opa_set[6];
        xlen_t       opb_set[6];
        logic [2:0]  conds[6];
        logic [12:0] imm;
        xlen_t       pc;
        logic        exp;
        string       nm;
        fails0 = fail_cnt;
        // equal, smaller, larger, then mixed and negative signs
        opa_set = '{64'd5, 64'd5, 64'd9, -64'sd5, 64'd3, -64'sd7};
        opb_set = '{64'd5, 64'd9, 64'd5, 64'd3, -64'sd5, -64'sd2};
        conds   = '{F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU};
        foreach (conds[c]) begin
            for (int p = 0; p < 6; p++) begin
                imm = {12'($random(seed)), 1'b0};
                pc  = rand64();
                exp = branch_rule(conds[c], opa_set[p], opb_set[p]);
                nm  = $sformatf("branch f3=%0d pair %0d", conds[c], p);
                ex_in = make_item(b_type(imm, conds[c]), pc, opa_set[p], opb_set[p], 5'd4);
                step();
                check_flag(nm, exp, jmp.taken);
                if (exp) begin
                    check_word(nm, pc + {{51{imm[12]}}, imm}, jmp.target);
                end
                check_flag(nm, 1'b0, wb.we);
            end
        end
        ex_in = '0;
        end_test("branches", fails0);
    endtask

    task automatic back_to_back();
        int unsigned fails0;
        ex_in_t seq[5];
        logic   exp_we[5];
        logic   exp_ce[5];
        logic   exp_tk[5];
        xlen_t  exp_data[5];
        xlen_t  a;
        xlen_t  b;
        string  nm;
        fails0 = fail_cnt;
        a = rand64();
        b = rand64();
        seq[0] = make_item(r_type(F7_BASE, F3_ADD_SUB, OPC_OP), 64'h100, a, b, 5'd1);
        seq[1] = make_item(r_type(7'b0000001, F3_ADD_SUB, OPC_OP), 64'h104, a, b, 5'd2);  // mul
        seq[2] = make_item(i_type(12'h7ff, F3_XOR, OPC_OP_IMM), 64'h108, a, b, 5'd3);
        seq[3] = make_item(s_type(12'h010, F3_SD), 64'h10c, a, b, 5'd4);
        seq[4] = make_item(b_type(13'h020, F3_BEQ), 64'h110, a, a, 5'd5);
        exp_we   = '{1'b1, 1'b0, 1'b1, 1'b0, 1'b0};
        exp_ce   = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b0};   // mem we follows ce with no load here
        exp_tk   = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b1};
        exp_data = '{a + b, 64'h0, a ^ 64'h7ff, 64'h0, 64'h0};
        ex_in = seq[0];
        for (int i = 0; i < 5; i++) begin
            step();
            if (i < 4) begin
                ex_in = seq[i + 1];
            end else begin
                ex_in = '0;
            end
            nm = $sformatf("item %0d", i);
            check_flag(nm, exp_we[i], wb.we);
            check_flag(nm, exp_ce[i], mem.ce);
            check_flag(nm, exp_ce[i], mem.we);
            check_flag(nm, exp_tk[i], jmp.taken);
            check_word(nm, exp_data[i], wb.data);
        end
        check_word("item 4 target", 64'h130, jmp.target);
        step();
        check_idle("after burst");
        end_test("back-to-back", fails0);
    endtask

    initial begin
        rst_n = 1'b0;
        ex_in = '0;
        reset_idle();
        alu_ops();
        word_ops();
        mem_ops();
        branch_ops();
        back_to_back();
        $display("checks passed: %0d, checks failed: %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire
